// ==== accelerator_macros.svh ====
// Word, field and opcode widths shared by the scalar float unit
`ifndef ACCELERATOR_MACROS_SVH
`define ACCELERATOR_MACROS_SVH

//////////////////////////////
// Word layout
//////////////////////////////

// Full double-precision word
`define ACCELERATOR_DATA_SIZE 64

// Biased exponent field
`define ACCELERATOR_EXPONENT_SIZE 11

// Fraction field, hidden bit not stored
`define ACCELERATOR_MANTISSA_SIZE 52

//////////////////////////////
// Control
//////////////////////////////

// Add, sub, mul, div
`define ACCELERATOR_OPCODE_SIZE 2

`endif

// ==== accelerator_arithmetic_pkg.sv ====
// Double-precision field struct and raw/field word union
`include "accelerator_macros.svh"

package accelerator_arithmetic_pkg;

  //////////////////////////////
  // IEEE-754 binary64 fields
  //////////////////////////////

  // MSB first, matches the raw bit order
  typedef struct packed {
    logic                                  sign;
    logic [`ACCELERATOR_EXPONENT_SIZE-1:0] exponent;
    logic [`ACCELERATOR_MANTISSA_SIZE-1:0] mantissa;
  } float_fields_t;

  //////////////////////////////
  // Word views
  //////////////////////////////

  // Same 64 bits seen two ways
  // Raw view for real conversion
  // Field view for sign flip and exponent checks
  typedef union packed {
    logic [`ACCELERATOR_DATA_SIZE-1:0] raw;
    float_fields_t                     fields;
  } float_word_t;

endpackage

// ==== accelerator_control_pkg.sv ====
// Opcode and controller state enumerations
`include "accelerator_macros.svh"

package accelerator_control_pkg;

  //////////////////////////////
  // Operations
  //////////////////////////////

  // Sub is handled by the adder with B negated
  typedef enum logic [`ACCELERATOR_OPCODE_SIZE-1:0] {
    OP_ADD = 2'b00,
    OP_SUB = 2'b01,
    OP_MUL = 2'b10,
    OP_DIV = 2'b11
  } opcode_t;

  //////////////////////////////
  // Controller FSM
  //////////////////////////////

  typedef enum logic [1:0] {
    IDLE       = 2'b00,  // waiting on req
    DISPATCH   = 2'b01,  // start pulse out
    WAIT_READY = 2'b10,  // datapath busy
    HOLD_ACK   = 2'b11   // ack high until req drops
  } control_state_t;

endpackage

// ==== accelerator_scalar_float_if.sv ====
// Start/ready bus between the controller and one float datapath
`timescale 1ns/1ps

interface accelerator_scalar_float_if
  import accelerator_arithmetic_pkg::*;
();

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // One-cycle pulses
  logic start;
  logic ready;

  //////////////////////////////
  // Payload
  //////////////////////////////

  // Operands valid in the start cycle
  float_word_t data_a;
  float_word_t data_b;

  // Held from ready until the next start
  float_word_t data_out;
  logic        overflow;

  // Controller side
  modport controller (
    output start,
    output data_a,
    output data_b,
    input  ready,
    input  data_out,
    input  overflow
  );

  // Datapath side
  modport datapath (
    input  start,
    input  data_a,
    input  data_b,
    output ready,
    output data_out,
    output overflow
  );

endinterface

// ==== accelerator_scalar_float_adder.sv ====
// Two-state double-precision adder datapath with overflow flag
`timescale 1ns/1ps

module accelerator_scalar_float_adder
  import accelerator_arithmetic_pkg::*;
(
  input logic CLK,
  input logic RST,

  accelerator_scalar_float_if.datapath bus
);

  // FSM encoding
  localparam logic STARTER_STATE = 1'b0;
  localparam logic ENDER_STATE   = 1'b1;

  logic        adder_fsm;

  // Operands as reals
  real         data_a_int;
  real         data_b_int;

  // Inf or NaN on an input, not an overflow
  logic        special_operand;

  float_word_t sum_word;

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Sum converted back to bits
  always_comb begin
    sum_word.raw = $realtobits(data_a_int + data_b_int);
  end

  always_ff @(posedge CLK) begin
    if (adder_fsm == STARTER_STATE && bus.start) begin
      data_a_int      <= $bitstoreal(bus.data_a.raw);
      data_b_int      <= $bitstoreal(bus.data_b.raw);
      special_operand <= (bus.data_a.fields.exponent == '1) ||
                         (bus.data_b.fields.exponent == '1);
    end
    if (adder_fsm == ENDER_STATE) begin
      bus.data_out <= sum_word;
      // All-ones exponent from finite inputs
      bus.overflow <= (sum_word.fields.exponent == '1) && !special_operand;
    end
  end

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      adder_fsm <= STARTER_STATE;
      bus.ready <= 1'b0;
    end else begin
      case (adder_fsm)
        STARTER_STATE: begin
          bus.ready <= 1'b0;
          if (bus.start) begin
            adder_fsm <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          // Result lands with this pulse
          bus.ready <= 1'b1;
          adder_fsm <= STARTER_STATE;
        end
        default: adder_fsm <= STARTER_STATE;
      endcase
    end
  end

endmodule

// ==== accelerator_scalar_float_multiplier.sv ====
// Two-state double-precision multiplier datapath with overflow flag
`timescale 1ns/1ps

module accelerator_scalar_float_multiplier
  import accelerator_arithmetic_pkg::*;
(
  input logic CLK,
  input logic RST,

  accelerator_scalar_float_if.datapath bus
);

  // FSM encoding
  localparam logic STARTER_STATE = 1'b0;
  localparam logic ENDER_STATE   = 1'b1;

  logic        multiplier_fsm;

  // Operands as reals
  real         data_a_int;
  real         data_b_int;

  // Set when either input is already Inf or NaN
  logic        special_operand;

  float_word_t product_word;

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Product converted back to bits
  always_comb begin
    product_word.raw = $realtobits(data_a_int * data_b_int);
  end

  always_ff @(posedge CLK) begin
    if (multiplier_fsm == STARTER_STATE && bus.start) begin
      data_a_int      <= $bitstoreal(bus.data_a.raw);
      data_b_int      <= $bitstoreal(bus.data_b.raw);
      special_operand <= (bus.data_a.fields.exponent == '1) ||
                         (bus.data_b.fields.exponent == '1);
    end
    if (multiplier_fsm == ENDER_STATE) begin
      bus.data_out <= product_word;
      // Large exponents add up past the top
      bus.overflow <= (product_word.fields.exponent == '1) && !special_operand;
    end
  end

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      multiplier_fsm <= STARTER_STATE;
      bus.ready      <= 1'b0;
    end else begin
      case (multiplier_fsm)
        STARTER_STATE: begin
          bus.ready <= 1'b0;
          if (bus.start) begin
            multiplier_fsm <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          bus.ready      <= 1'b1;
          multiplier_fsm <= STARTER_STATE;
        end
        default: multiplier_fsm <= STARTER_STATE;
      endcase
    end
  end

endmodule

// ==== accelerator_scalar_float_divider.sv ====
// Two-state double-precision divider datapath with overflow flag
`timescale 1ns/1ps

module accelerator_scalar_float_divider
  import accelerator_arithmetic_pkg::*;
(
  input logic CLK,
  input logic RST,

  accelerator_scalar_float_if.datapath bus
);

  // FSM encoding
  localparam logic STARTER_STATE = 1'b0;
  localparam logic ENDER_STATE   = 1'b1;

  logic        divider_fsm;

  // Dividend and divisor as reals
  real         data_a_int;
  real         data_b_int;

  // Inf or NaN on an input
  logic        special_operand;

  float_word_t quotient_word;

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Zero divisor gives Inf, caught by the exponent rule
  always_comb begin
    quotient_word.raw = $realtobits(data_a_int / data_b_int);
  end

  always_ff @(posedge CLK) begin
    if (divider_fsm == STARTER_STATE && bus.start) begin
      data_a_int      <= $bitstoreal(bus.data_a.raw);
      data_b_int      <= $bitstoreal(bus.data_b.raw);
      special_operand <= (bus.data_a.fields.exponent == '1) ||
                         (bus.data_b.fields.exponent == '1);
    end
    if (divider_fsm == ENDER_STATE) begin
      bus.data_out <= quotient_word;
      bus.overflow <= (quotient_word.fields.exponent == '1) && !special_operand;
    end
  end

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      divider_fsm <= STARTER_STATE;
      bus.ready   <= 1'b0;
    end else begin
      case (divider_fsm)
        STARTER_STATE: begin
          bus.ready <= 1'b0;
          if (bus.start) begin
            divider_fsm <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          bus.ready   <= 1'b1;
          divider_fsm <= STARTER_STATE;
        end
        default: divider_fsm <= STARTER_STATE;
      endcase
    end
  end

endmodule

// ==== accelerator_scalar_float_controller.sv ====
// Four-phase front end, opcode decode and datapath dispatch
`timescale 1ns/1ps

module accelerator_scalar_float_controller
  import accelerator_arithmetic_pkg::*;
  import accelerator_control_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,

  // Requester handshake
  input  logic        req,
  output logic        ack,

  input  opcode_t     opcode,
  input  float_word_t operand_a,
  input  float_word_t operand_b,

  output float_word_t result,
  output logic        overflow,

  // Datapath buses
  accelerator_scalar_float_if.controller add_bus,
  accelerator_scalar_float_if.controller mul_bus,
  accelerator_scalar_float_if.controller div_bus
);

  control_state_t state;

  // Request captured in IDLE
  opcode_t        opcode_q;
  float_word_t    op_a_q;
  float_word_t    op_b_q;

  // B with sign flipped for sub
  float_word_t    operand_b_signed;

  // Selected datapath return path
  logic           sel_ready;
  float_word_t    sel_data;
  logic           sel_overflow;

  //////////////////////////////
  // Operand path
  //////////////////////////////

  // A - B becomes A + (-B)
  always_comb begin
    operand_b_signed.raw = operand_b.raw;
    if (opcode == OP_SUB) begin
      operand_b_signed.fields.sign = ~operand_b.fields.sign;
    end
  end

  always_ff @(posedge CLK) begin
    if (state == IDLE && req) begin
      opcode_q <= opcode;
      op_a_q   <= operand_a;
      op_b_q   <= operand_b_signed;
    end
  end

  // Same operands go to every datapath, start picks one
  assign add_bus.data_a = op_a_q;
  assign add_bus.data_b = op_b_q;
  assign mul_bus.data_a = op_a_q;
  assign mul_bus.data_b = op_b_q;
  assign div_bus.data_a = op_a_q;
  assign div_bus.data_b = op_b_q;

  // Return mux
  always_comb begin
    sel_ready    = add_bus.ready;
    sel_data     = add_bus.data_out;
    sel_overflow = add_bus.overflow;
    case (opcode_q)
      OP_MUL: begin
        sel_ready    = mul_bus.ready;
        sel_data     = mul_bus.data_out;
        sel_overflow = mul_bus.overflow;
      end
      OP_DIV: begin
        sel_ready    = div_bus.ready;
        sel_data     = div_bus.data_out;
        sel_overflow = div_bus.overflow;
      end
      default: ;
    endcase
  end

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state         <= IDLE;
      ack           <= 1'b0;
      result        <= '0;
      overflow      <= 1'b0;
      add_bus.start <= 1'b0;
      mul_bus.start <= 1'b0;
      div_bus.start <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            state <= DISPATCH;
          end
        end
        DISPATCH: begin
          // Single start pulse on the decoded bus
          case (opcode_q)
            OP_ADD, OP_SUB: add_bus.start <= 1'b1;
            OP_MUL:         mul_bus.start <= 1'b1;
            OP_DIV:         div_bus.start <= 1'b1;
            default:        add_bus.start <= 1'b0;
          endcase
          state <= WAIT_READY;
        end
        WAIT_READY: begin
          add_bus.start <= 1'b0;
          mul_bus.start <= 1'b0;
          div_bus.start <= 1'b0;
          if (sel_ready) begin
            result   <= sel_data;
            overflow <= sel_overflow;
            ack      <= 1'b1;
            state    <= HOLD_ACK;
          end
        end
        HOLD_ACK: begin
          // Outputs frozen while req stays high
          if (!req) begin
            ack   <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// ==== accelerator_scalar_float_unit.sv ====
// Scalar float unit top with controller, buses and three datapaths
`timescale 1ns/1ps
`include "accelerator_macros.svh"

module accelerator_scalar_float_unit
  import accelerator_arithmetic_pkg::*;
  import accelerator_control_pkg::*;
(
  input  logic                                CLK,
  input  logic                                RST,

  // Four-phase handshake
  input  logic                                req,
  output logic                                ack,

  input  logic [`ACCELERATOR_OPCODE_SIZE-1:0] opcode,
  input  logic [`ACCELERATOR_DATA_SIZE-1:0]   operand_a,
  input  logic [`ACCELERATOR_DATA_SIZE-1:0]   operand_b,

  output logic [`ACCELERATOR_DATA_SIZE-1:0]   result,
  output logic                                overflow
);

  // Typed views of the port vectors
  opcode_t     opcode_enum;
  float_word_t operand_a_word;
  float_word_t operand_b_word;
  float_word_t result_word;

  assign opcode_enum        = opcode_t'(opcode);
  assign operand_a_word.raw = operand_a;
  assign operand_b_word.raw = operand_b;
  assign result             = result_word.raw;

  //////////////////////////////
  // Datapath buses
  //////////////////////////////

  accelerator_scalar_float_if add_bus ();
  accelerator_scalar_float_if mul_bus ();
  accelerator_scalar_float_if div_bus ();

  //////////////////////////////
  // Instances
  //////////////////////////////

  accelerator_scalar_float_controller i_controller (
    .CLK       (CLK),
    .RST       (RST),
    .req       (req),
    .ack       (ack),
    .opcode    (opcode_enum),
    .operand_a (operand_a_word),
    .operand_b (operand_b_word),
    .result    (result_word),
    .overflow  (overflow),
    .add_bus   (add_bus),
    .mul_bus   (mul_bus),
    .div_bus   (div_bus)
  );

  // Add and sub share this one
  accelerator_scalar_float_adder i_adder (
    .CLK (CLK),
    .RST (RST),
    .bus (add_bus)
  );

  accelerator_scalar_float_multiplier i_multiplier (
    .CLK (CLK),
    .RST (RST),
    .bus (mul_bus)
  );

  accelerator_scalar_float_divider i_divider (
    .CLK (CLK),
    .RST (RST),
    .bus (div_bus)
  );

endmodule

// ==== accelerator_scalar_float_unit_tb.sv ====
// Scalar float unit testbench with clock, reset, random stimulus, real model and compare tasks
`timescale 1ns/1ps
`include "accelerator_macros.svh"

module accelerator_scalar_float_unit_tb
  import accelerator_arithmetic_pkg::*;
  import accelerator_control_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20;
  localparam int RANDOM_OPS     = 200;
  localparam int SEQUENCE_OPS   = 400;

  logic                                CLK = 1'b0;
  logic                                RST;
  logic                                req;
  logic                                ack;
  logic [`ACCELERATOR_OPCODE_SIZE-1:0] opcode;
  logic [`ACCELERATOR_DATA_SIZE-1:0]   operand_a;
  logic [`ACCELERATOR_DATA_SIZE-1:0]   operand_b;
  logic [`ACCELERATOR_DATA_SIZE-1:0]   result;
  logic                                overflow;

  // Field view of the result port
  float_word_t result_view;
  assign result_view.raw = result;

  logic [31:0] lcg_state = 32'ha3aaf343;

  // 4 ns period
  always #2 CLK = ~CLK;

  accelerator_scalar_float_unit i_accelerator_scalar_float_unit (
    .CLK       (CLK),
    .RST       (RST),
    .req       (req),
    .ack       (ack),
    .opcode    (opcode),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .result    (result),
    .overflow  (overflow)
  );

  //////////////////////////////
  // Stimulus and model
  //////////////////////////////

  function logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Range 0 mixed, 1 near the top, 2 tiny
  // Exponent never all ones
  function float_word_t make_operand(input int range_sel);
    float_word_t w;
    logic [31:0] r;
    r                 = next_random();
    w.fields.sign     = r[31];
    w.fields.mantissa = {r[19:0], next_random()};
    r                 = next_random();
    case (range_sel)
      1:       w.fields.exponent = 11'h7F0 + 11'(r % 32'd15);
      2:       w.fields.exponent = 11'd1 + 11'(r % 32'd64);
      default: begin
        if (r[30:28] == 3'd0) begin
          w.fields.exponent = 11'h7F0 + 11'(r % 32'd15);
        end else begin
          w.fields.exponent = 11'd960 + 11'(r % 32'd128);
        end
      end
    endcase
    return w;
  endfunction

  function float_word_t model_result(input opcode_t op, input float_word_t a,
                                     input float_word_t b);
    real         ra;
    real         rb;
    real         rr;
    float_word_t w;
    ra = $bitstoreal(a.raw);
    rb = $bitstoreal(b.raw);
    case (op)
      OP_ADD:  rr = ra + rb;
      OP_SUB:  rr = ra - rb;
      OP_MUL:  rr = ra * rb;
      default: rr = ra / rb;
    endcase
    w.raw = $realtobits(rr);
    return w;
  endfunction

  // All-ones exponent out of finite operands
  function logic model_overflow(input float_word_t a, input float_word_t b,
                                input float_word_t res);
    return (res.fields.exponent == '1) && (a.fields.exponent != '1) &&
           (b.fields.exponent != '1);
  endfunction

  //////////////////////////////
  // Checks
  //////////////////////////////

  task report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Stopping at first error");
  endtask

  task check_result(input float_word_t actual, input float_word_t expected, input string what);
    if (actual !== expected) begin
      report_failure($sformatf("MISMATCH at %0t: %s result %h, expected %h",
                               $time, what, actual.raw, expected.raw));
    end
  endtask

  task check_overflow(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      report_failure($sformatf("MISMATCH at %0t: %s overflow %b, expected %b",
                               $time, what, actual, expected));
    end
  endtask

  task check_ack(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      report_failure($sformatf("MISMATCH at %0t: %s ack %b, expected %b",
                               $time, what, actual, expected));
    end
  endtask

  // Sampled on falling edges only
  task wait_ack(input logic level, input string what);
    int cycles;
    cycles = 0;
    while (ack !== level) begin
      @(negedge CLK);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        report_failure($sformatf("Timeout: ack never went to %0b during %s", level, what));
      end
    end
  endtask

  // One full four-phase transfer between falling edges
  task run_op(input opcode_t op, input float_word_t a, input float_word_t b,
              input int hold_cycles, input string what);
    float_word_t exp_res;
    logic        exp_ovf;
    int          i;
    check_ack(ack, 1'b0, {what, " before req"});
    exp_res   = model_result(op, a, b);
    exp_ovf   = model_overflow(a, b, exp_res);
    opcode    = op;
    operand_a = a.raw;
    operand_b = b.raw;
    req       = 1'b1;
    @(negedge CLK);
    wait_ack(1'b1, what);
    check_result(result_view, exp_res, what);
    check_overflow(overflow, exp_ovf, what);
    // Inputs scrambled while ack stays up
    for (i = 0; i < hold_cycles; i++) begin
      opcode    = 2'(next_random());
      operand_a = {next_random(), next_random()};
      @(negedge CLK);
      check_ack(ack, 1'b1, {what, " held"});
      check_result(result_view, exp_res, {what, " held"});
      check_overflow(overflow, exp_ovf, {what, " held"});
    end
    req = 1'b0;
    wait_ack(1'b0, what);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    float_word_t a;
    float_word_t b;
    float_word_t zero_word;
    opcode_t     op;
    logic [31:0] r;
    int          n;
    RST       = 1'b1;
    req       = 1'b0;
    opcode    = '0;
    operand_a = '0;
    operand_b = '0;
    zero_word = '0;
    repeat (3) @(negedge CLK);
    RST = 1'b0;
    check_ack(ack, 1'b0, "reset");
    check_overflow(overflow, 1'b0, "reset");
    check_result(result_view, zero_word, "reset");

    // Add and sub over mixed then large exponents
    for (n = 0; n < RANDOM_OPS; n++) begin
      a = make_operand(0);
      b = make_operand(0);
      run_op(n[0] ? OP_SUB : OP_ADD, a, b, 0, $sformatf("add/sub #%0d", n));
    end
    for (n = 0; n < 20; n++) begin
      a = make_operand(1);
      b = make_operand(1);
      run_op(n[0] ? OP_SUB : OP_ADD, a, b, 0, $sformatf("large add/sub #%0d", n));
    end

    // Mul and div with large-exponent pairs
    for (n = 0; n < RANDOM_OPS; n++) begin
      r = next_random();
      a = make_operand((r[1:0] == 2'd0) ? 1 : 0);
      b = make_operand((r[1:0] == 2'd0) ? 1 : 0);
      run_op(OP_MUL, a, b, 0, $sformatf("mul #%0d", n));
      a = make_operand(r[2] ? 1 : 0);
      b = make_operand(r[3] ? 2 : 0);
      run_op(OP_DIV, a, b, 0, $sformatf("div #%0d", n));
    end

    // Zero divisor with a finite dividend
    for (n = 0; n < 8; n++) begin
      r             = next_random();
      a             = make_operand(0);
      b             = '0;
      b.fields.sign = r[5];
      run_op(OP_DIV, a, b, 0, $sformatf("div by zero #%0d", n));
    end

    // Req held past ack
    for (n = 0; n < 30; n++) begin
      r  = next_random();
      op = opcode_t'(r[1:0]);
      a  = make_operand(0);
      b  = make_operand(0);
      run_op(op, a, b, 1 + int'(r[5:2]), $sformatf("back-pressure #%0d", n));
    end

    // Mixed opcodes back to back
    for (n = 0; n < SEQUENCE_OPS; n++) begin
      r  = next_random();
      op = opcode_t'(r[9:8]);
      a  = make_operand(0);
      b  = make_operand(0);
      run_op(op, a, b, 0, $sformatf("sequence #%0d", n));
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
accelerator_arithmetic_pkg.sv
accelerator_control_pkg.sv
accelerator_scalar_float_if.sv
accelerator_scalar_float_adder.sv
accelerator_scalar_float_multiplier.sv
accelerator_scalar_float_divider.sv
accelerator_scalar_float_controller.sv
accelerator_scalar_float_unit.sv
accelerator_scalar_float_unit_tb.sv

// ==== Bender.yml ====
package:
  name: accelerator_scalar_float_unit

export_include_dirs:
  - .

sources:
  - accelerator_arithmetic_pkg.sv
  - accelerator_control_pkg.sv
  - accelerator_scalar_float_if.sv
  - accelerator_scalar_float_adder.sv
  - accelerator_scalar_float_multiplier.sv
  - accelerator_scalar_float_divider.sv
  - accelerator_scalar_float_controller.sv
  - accelerator_scalar_float_unit.sv
  - target: test
    files:
      - accelerator_scalar_float_unit_tb.sv
